//--- all.f
alu_pkg.sv
xfer_pkg.sv
alu_logic.sv
alu_adder.sv
alu_shift.sv
alu_pack.sv
alu_core.sv
hs_slot.sv
exec_unit.sv
exec_assertions.sv
exec_tb.sv

//--- alu_adder.sv
`default_nettype none

module alu_adder (
    input  xfer_pkg::alu_req_t         req,
    output logic [alu_pkg::data_w-1:0] add_out,
    output logic                       add_cf,
    output logic [alu_pkg::data_w-1:0] paddw_out,
    output logic [alu_pkg::data_w-1:0] paddd_out
);

    logic [31:0] add_b;
    logic [32:0] sum;

    ////////////////////////////////////////////////////////////
    // 32-bit step adder
    ////////////////////////////////////////////////////////////

    // Second operand from op2 or an immediate step
    always_comb begin
        case (req.step)
            alu_pkg::step_op2: add_b = req.op2[31:0];
            alu_pkg::step_p2:  add_b = 32'd2;
            alu_pkg::step_p4:  add_b = 32'd4;
            alu_pkg::step_p6:  add_b = 32'd6;
            alu_pkg::step_m2:  add_b = 32'hffff_fffe;
            alu_pkg::step_m4:  add_b = 32'hffff_fffc;
            default:           add_b = 32'd0;
        endcase
    end

    assign sum = {1'b0, req.op1[31:0]} + {1'b0, add_b};

    // Sign extend from bit 31, carry out of bit 31
    assign add_out = {{32{sum[31]}}, sum[31:0]};
    assign add_cf  = sum[32];

    ////////////////////////////////////////////////////////////
    // Packed adds, each lane wraps on its own
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < 4; w++) begin
            paddw_out[16*w +: 16] = req.op1[16*w +: 16] + req.op2[16*w +: 16];
        end
    end

    always_comb begin
        for (int d = 0; d < 2; d++) begin
            paddd_out[32*d +: 32] = req.op1[32*d +: 32] + req.op2[32*d +: 32];
        end
    end

endmodule

`default_nettype wire

//--- alu_core.sv
`default_nettype none

module alu_core (
    input  xfer_pkg::alu_req_t req,
    output xfer_pkg::alu_res_t res
);

    logic [alu_pkg::data_w-1:0] and_out;
    logic [alu_pkg::data_w-1:0] not_out;
    logic [alu_pkg::data_w-1:0] bsf_out;
    logic                       bsf_invalid;
    logic [alu_pkg::data_w-1:0] add_out;
    logic                       add_cf;
    logic [alu_pkg::data_w-1:0] paddw_out;
    logic [alu_pkg::data_w-1:0] paddd_out;
    logic [alu_pkg::data_w-1:0] shift_out;
    logic                       shift_cf;
    logic [alu_pkg::data_w-1:0] pack_out;

    ////////////////////////////////////////////////////////////
    // Functional blocks, all evaluated in parallel
    ////////////////////////////////////////////////////////////

    alu_logic i_logic (
        .req         (req),
        .and_out     (and_out),
        .not_out     (not_out),
        .bsf_out     (bsf_out),
        .bsf_invalid (bsf_invalid)
    );

    alu_adder i_adder (
        .req       (req),
        .add_out   (add_out),
        .add_cf    (add_cf),
        .paddw_out (paddw_out),
        .paddd_out (paddd_out)
    );

    alu_shift i_shift (
        .req       (req),
        .shift_out (shift_out),
        .shift_cf  (shift_cf)
    );

    alu_pack i_pack (
        .req      (req),
        .pack_out (pack_out)
    );

    ////////////////////////////////////////////////////////////
    // Result and flag select
    ////////////////////////////////////////////////////////////

    always_comb begin
        res.cf = 1'b0;
        case (req.op)
            alu_pkg::op_and,
            alu_pkg::op_and_low16: res.value = and_out;
            alu_pkg::op_add: begin
                res.value = add_out;
                res.cf    = add_cf;
            end
            alu_pkg::op_paddw:  res.value = paddw_out;
            alu_pkg::op_paddd:  res.value = paddd_out;
            alu_pkg::op_not:    res.value = not_out;
            alu_pkg::op_pass_a: res.value = req.op1;
            alu_pkg::op_pass_b: res.value = req.op2;
            alu_pkg::op_sal,
            alu_pkg::op_sar: begin
                res.value = shift_out;
                res.cf    = shift_cf;
            end
            alu_pkg::op_bsf:    res.value = bsf_out;
            default:            res.value = pack_out;
        endcase
        // Scan reports invalid input instead of a zero result
        res.zf = (req.op == alu_pkg::op_bsf) ? bsf_invalid : (res.value == '0);
    end

endmodule

`default_nettype wire

//--- alu_logic.sv
`default_nettype none

module alu_logic (
    input  xfer_pkg::alu_req_t         req,
    output logic [alu_pkg::data_w-1:0] and_out,
    output logic [alu_pkg::data_w-1:0] not_out,
    output logic [alu_pkg::data_w-1:0] bsf_out,
    output logic                       bsf_invalid
);

    logic [alu_pkg::data_w-1:0] and_mask;
    logic [4:0]                 bsf_idx;

    // Second AND operand is op2 or the low 16 bit mask
    assign and_mask = (req.op == alu_pkg::op_and_low16) ? 64'h0000_0000_0000_ffff : req.op2;
    assign and_out  = req.op1 & and_mask;

    assign not_out = ~req.op1;

    ////////////////////////////////////////////////////////////
    // Bit scan forward over op1[31:0]
    ////////////////////////////////////////////////////////////

    // Scan from the top so the lowest set bit wins
    always_comb begin
        bsf_idx = 5'd0;
        for (int i = 31; i >= 0; i--) begin
            if (req.op1[i]) begin
                bsf_idx = 5'(i);
            end
        end
    end

    assign bsf_invalid = (req.op1[31:0] == 32'd0);
    assign bsf_out     = {59'd0, bsf_idx};

endmodule

`default_nettype wire

//--- alu_pack.sv
`default_nettype none

module alu_pack (
    input  xfer_pkg::alu_req_t         req,
    output logic [alu_pkg::data_w-1:0] pack_out
);

    logic [alu_pkg::data_w-1:0] packsswb;
    logic [alu_pkg::data_w-1:0] packssdw;
    logic [alu_pkg::data_w-1:0] unpckhbw;
    logic [alu_pkg::data_w-1:0] unpckhwd;

    function automatic logic [7:0] sat_w2b(input logic signed [15:0] w);
        if (w > 16'sd127)       return 8'h7f;
        else if (w < -16'sd128) return 8'h80;
        else                    return w[7:0];
    endfunction

    function automatic logic [15:0] sat_d2w(input logic signed [31:0] d);
        if (d > 32'sd32767)       return 16'h7fff;
        else if (d < -32'sd32768) return 16'h8000;
        else                      return d[15:0];
    endfunction

    // Low half from op1, high half from op2
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            packsswb[8*i +: 8]      = sat_w2b(req.op1[16*i +: 16]);
            packsswb[8*(i+4) +: 8]  = sat_w2b(req.op2[16*i +: 16]);
            unpckhbw[16*i +: 8]     = req.op1[8*(i+4) +: 8];
            unpckhbw[16*i+8 +: 8]   = req.op2[8*(i+4) +: 8];
        end
        for (int j = 0; j < 2; j++) begin
            packssdw[16*j +: 16]     = sat_d2w(req.op1[32*j +: 32]);
            packssdw[16*(j+2) +: 16] = sat_d2w(req.op2[32*j +: 32]);
            unpckhwd[32*j +: 16]     = req.op1[16*(j+2) +: 16];
            unpckhwd[32*j+16 +: 16]  = req.op2[16*(j+2) +: 16];
        end
    end

    always_comb begin
        case (req.op)
            alu_pkg::op_packsswb:  pack_out = packsswb;
            alu_pkg::op_packssdw:  pack_out = packssdw;
            alu_pkg::op_punpckhbw: pack_out = unpckhbw;
            default:               pack_out = unpckhwd;
        endcase
    end

endmodule

`default_nettype wire

//--- alu_pkg.sv
`default_nettype none

package alu_pkg;

    // Operand width of the execute unit
    localparam int data_w = 64;

    typedef enum logic [3:0] {
        op_and       = 4'd0,
        op_and_low16 = 4'd1,
        op_add       = 4'd2,
        op_paddw     = 4'd3,
        op_paddd     = 4'd4,
        op_not       = 4'd5,
        op_pass_a    = 4'd6,
        op_pass_b    = 4'd7,
        op_sal       = 4'd8,
        op_sar       = 4'd9,
        op_bsf       = 4'd10,
        op_packsswb  = 4'd11,
        op_packssdw  = 4'd12,
        op_punpckhbw = 4'd13,
        op_punpckhwd = 4'd14
    } alu_op_e;

    // Adder second operand, codes 3 and 7 unused
    typedef enum logic [2:0] {
        step_op2 = 3'd0,
        step_p2  = 3'd1,
        step_p4  = 3'd2,
        step_p6  = 3'd4,
        step_m2  = 3'd5,
        step_m4  = 3'd6
    } add_step_e;

endpackage

`default_nettype wire

//--- alu_shift.sv
`default_nettype none

module alu_shift (
    input  xfer_pkg::alu_req_t         req,
    output logic [alu_pkg::data_w-1:0] shift_out,
    output logic                       shift_cf
);

    logic [5:0]                 cnt;
    logic [alu_pkg::data_w:0]   sal_ext;
    logic [alu_pkg::data_w:0]   sar_ext;
    logic [alu_pkg::data_w-1:0] sal_val;
    logic [alu_pkg::data_w-1:0] sar_val;
    logic                       sal_cf;
    logic                       sar_cf;

    assign cnt = req.op2[5:0];

    ////////////////////////////////////////////////////////////
    // Shift one extra bit to catch the last bit out
    ////////////////////////////////////////////////////////////

    // Carry bit sits above the MSB, zeros enter on the right
    assign sal_ext = {1'b0, req.op1} << cnt;
    assign sal_val = sal_ext[alu_pkg::data_w-1:0];
    assign sal_cf  = sal_ext[alu_pkg::data_w];

    // Carry bit sits below the LSB, sign bit copied in
    assign sar_ext = $signed({req.op1, 1'b0}) >>> cnt;
    assign sar_val = sar_ext[alu_pkg::data_w:1];
    assign sar_cf  = sar_ext[0];

    // A zero count leaves the spare bit clear in both cases

    always_comb begin
        if (req.op == alu_pkg::op_sar) begin
            shift_out = sar_val;
            shift_cf  = sar_cf;
        end else begin
            shift_out = sal_val;
            shift_cf  = sal_cf;
        end
    end

endmodule

`default_nettype wire

//--- exec_assertions.sv
`default_nettype none

module exec_assertions #(
    parameter type payload_t = logic
) (
    input logic     clk,
    input logic     rst,
    input logic     up_req,
    input logic     up_ack,
    input payload_t up_data,
    input logic     dn_req,
    input logic     dn_ack,
    input payload_t dn_data
);

    int rise_fails = 0;
    int hold_fails = 0;
    int rst_fails  = 0;
    int fail_cnt;

    assign fail_cnt = rise_fails + hold_fails + rst_fails;

    ////////////////////////////////////////////////////////////
    // Four-phase rules on both sides of the slot
    ////////////////////////////////////////////////////////////

    // The slot raises a new req only once it has seen the previous ack low
    a_req_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(dn_req) |-> !$past(dn_ack))
        else begin
            rise_fails++;
            $error("req rose while ack was still high");
        end

    // Payload stays put until the receiver acks
    a_data_hold: assert property (@(posedge clk) disable iff (rst)
        ((up_req && !up_ack) |=> (up_ack || $stable(up_data))) and
        ((dn_req && !dn_ack) |=> (dn_ack || $stable(dn_data))))
        else begin
            hold_fails++;
            $error("payload changed before ack");
        end

    a_reset_idle: assert property (@(posedge clk) rst |=> (!up_ack && !dn_req))
        else begin
            rst_fails++;
            $error("ack or req high right after reset");
        end

endmodule

bind hs_slot exec_assertions #(.payload_t(payload_t)) i_hs_assert (
    .clk     (clk),
    .rst     (rst),
    .up_req  (up_req),
    .up_ack  (up_ack),
    .up_data (up_data),
    .dn_req  (dn_req),
    .dn_ack  (dn_ack),
    .dn_data (dn_data)
);

`default_nettype wire

//--- exec_tb.sv
`default_nettype none

module exec_tb;

    localparam int n_random = 400;

    logic               clk;
    logic               rst;
    logic               in_req;
    logic               in_ack;
    xfer_pkg::alu_req_t in_data;
    logic               out_req;
    logic               out_ack;
    xfer_pkg::alu_res_t out_data;

    xfer_pkg::alu_req_t stim_q[$];
    xfer_pkg::alu_req_t src_q[$];
    xfer_pkg::alu_res_t exp_q[$];

    int n_ops      = 0;
    int n_done     = 0;
    int value_errs = 0;
    int flag_errs  = 0;
    int cap_errs   = 0;
    int other_errs = 0;

    exec_unit i_dut (
        .clk      (clk),
        .rst      (rst),
        .in_req   (in_req),
        .in_ack   (in_ack),
        .in_data  (in_data),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .out_data (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [7:0] sat_byte(input logic [15:0] w);
        int x;
        x = int'($signed(w));
        if (x > 127) x = 127;
        if (x < -128) x = -128;
        return 8'(x);
    endfunction

    function automatic logic [15:0] sat_word(input logic [31:0] d);
        int x;
        x = $signed(d);
        if (x > 32767) x = 32767;
        if (x < -32768) x = -32768;
        return 16'(x);
    endfunction

    function automatic xfer_pkg::alu_res_t predict_res(input xfer_pkg::alu_req_t r);
        xfer_pkg::alu_res_t e;
        logic [31:0]        b;
        logic [32:0]        s;
        logic [63:0]        v;
        logic               found;
        e     = '0;
        v     = r.op1;
        found = 1'b0;
        case (r.op)
            alu_pkg::op_and:       e.value = r.op1 & r.op2;
            alu_pkg::op_and_low16: e.value = {48'd0, r.op1[15:0]};
            alu_pkg::op_add: begin
                case (r.step)
                    alu_pkg::step_p2: b = 32'd2;
                    alu_pkg::step_p4: b = 32'd4;
                    alu_pkg::step_p6: b = 32'd6;
                    alu_pkg::step_m2: b = -32'd2;
                    alu_pkg::step_m4: b = -32'd4;
                    default:          b = r.op2[31:0];
                endcase
                s       = 33'(r.op1[31:0]) + 33'(b);
                e.value = 64'($signed(s[31:0]));
                e.cf    = s[32];
            end
            alu_pkg::op_paddw: begin
                for (int i = 0; i < 4; i++) begin
                    e.value[16*i +: 16] = r.op1[16*i +: 16] + r.op2[16*i +: 16];
                end
            end
            alu_pkg::op_paddd: begin
                e.value[31:0]  = r.op1[31:0] + r.op2[31:0];
                e.value[63:32] = r.op1[63:32] + r.op2[63:32];
            end
            alu_pkg::op_not:    e.value = ~r.op1;
            alu_pkg::op_pass_a: e.value = r.op1;
            alu_pkg::op_pass_b: e.value = r.op2;
            // One bit per step, carry keeps the last bit out
            alu_pkg::op_sal: begin
                repeat (r.op2[5:0]) begin
                    e.cf = v[63];
                    v    = v << 1;
                end
                e.value = v;
            end
            alu_pkg::op_sar: begin
                repeat (r.op2[5:0]) begin
                    e.cf = v[0];
                    v    = {v[63], v[63:1]};
                end
                e.value = v;
            end
            alu_pkg::op_bsf: begin
                for (int i = 0; i < 32; i++) begin
                    if (r.op1[i] && !found) begin
                        found   = 1'b1;
                        e.value = 64'(i);
                    end
                end
            end
            alu_pkg::op_packsswb: begin
                for (int i = 0; i < 4; i++) begin
                    e.value[8*i +: 8]    = sat_byte(r.op1[16*i +: 16]);
                    e.value[8*i+32 +: 8] = sat_byte(r.op2[16*i +: 16]);
                end
            end
            alu_pkg::op_packssdw: begin
                for (int i = 0; i < 2; i++) begin
                    e.value[16*i +: 16]    = sat_word(r.op1[32*i +: 32]);
                    e.value[16*i+32 +: 16] = sat_word(r.op2[32*i +: 32]);
                end
            end
            alu_pkg::op_punpckhbw: begin
                for (int i = 0; i < 4; i++) begin
                    e.value[16*i +: 8]   = r.op1[32+8*i +: 8];
                    e.value[16*i+8 +: 8] = r.op2[32+8*i +: 8];
                end
            end
            alu_pkg::op_punpckhwd: begin
                for (int i = 0; i < 2; i++) begin
                    e.value[32*i +: 16]    = r.op1[32+16*i +: 16];
                    e.value[32*i+16 +: 16] = r.op2[32+16*i +: 16];
                end
            end
            default: e.value = '0;
        endcase
        if (r.op == alu_pkg::op_bsf) e.zf = (r.op1[31:0] == 32'd0);
        else e.zf = (e.value == 64'd0);
        return e;
    endfunction

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic check_res(input xfer_pkg::alu_res_t got, input xfer_pkg::alu_res_t exp,
                             input xfer_pkg::alu_req_t src);
        if (got.value !== exp.value) begin
            value_errs++;
            $display("ERROR out_data.value got %h expected %h", got.value, exp.value);
        end
        if (got.cf !== exp.cf || got.zf !== exp.zf) begin
            flag_errs++;
            $display("ERROR out_data.cf/zf got %h/%h expected %h/%h",
                     got.cf, got.zf, exp.cf, exp.zf);
        end
        if (got !== exp) begin
            $display("  for op %0d step %0d op1 %h op2 %h", src.op, src.step, src.op1, src.op2);
        end
    endtask

    // Operand slot must hold exactly what was sent
    task automatic check_req(input xfer_pkg::alu_req_t got, input xfer_pkg::alu_req_t exp);
        if (got !== exp) begin
            cap_errs++;
            $display("ERROR op_data got %h expected %h", got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic push_op(input alu_pkg::alu_op_e op, input logic [63:0] a,
                           input logic [63:0] b, input alu_pkg::add_step_e step);
        xfer_pkg::alu_req_t r;
        r.op1  = a;
        r.op2  = b;
        r.op   = op;
        r.step = step;
        stim_q.push_back(r);
    endtask

    function automatic alu_pkg::add_step_e pick_step(input int unsigned k);
        case (k)
            0:       return alu_pkg::step_op2;
            1:       return alu_pkg::step_p2;
            2:       return alu_pkg::step_p4;
            3:       return alu_pkg::step_p6;
            4:       return alu_pkg::step_m2;
            default: return alu_pkg::step_m4;
        endcase
    endfunction

    function automatic xfer_pkg::alu_req_t rand_req();
        xfer_pkg::alu_req_t r;
        r.op1  = {$urandom, $urandom};
        r.op2  = {$urandom, $urandom};
        r.op   = alu_pkg::alu_op_e'(4'($urandom_range(14, 0)));
        r.step = pick_step($urandom_range(5, 0));
        // Empty scan window now and then
        if ($urandom_range(7, 0) == 0) r.op1[31:0] = 32'd0;
        return r;
    endfunction

    task automatic build_directed();
        logic [63:0] cnt;
        // Adder steps, sign extension and carry
        push_op(alu_pkg::op_add, 64'h0000_0000_7fff_fffe, '0, alu_pkg::step_p2);
        push_op(alu_pkg::op_add, 64'h1234_5678_ffff_fffe, '0, alu_pkg::step_p4);
        push_op(alu_pkg::op_add, 64'h0000_0000_7fff_fffa, '0, alu_pkg::step_p6);
        push_op(alu_pkg::op_add, 64'h0000_0000_0000_0002, '0, alu_pkg::step_m2);
        push_op(alu_pkg::op_add, 64'h0000_0000_0000_0001, '0, alu_pkg::step_m4);
        push_op(alu_pkg::op_add, 64'hffff_0000_9000_0000, 64'h9000_0000, alu_pkg::step_op2);
        // Counts 0, 1, 63 and one random, upper op2 bits ignored
        for (int k = 0; k < 4; k++) begin
            cnt = (k == 3) ? 64'($urandom_range(63, 0)) : ((k == 2) ? 64'd63 : 64'(k));
            cnt = cnt | 64'h100;
            push_op(alu_pkg::op_sal, 64'hc000_0000_0000_0005, cnt, alu_pkg::step_op2);
            push_op(alu_pkg::op_sar, 64'hc000_0000_0000_0005, cnt, alu_pkg::step_op2);
            push_op(alu_pkg::op_sar, 64'h4000_0000_0000_0003, cnt, alu_pkg::step_op2);
        end
        push_op(alu_pkg::op_bsf, 64'hffff_ffff_0000_0000, '0, alu_pkg::step_op2);
        push_op(alu_pkg::op_bsf, 64'h0000_0000_8000_0000, '0, alu_pkg::step_op2);
        push_op(alu_pkg::op_bsf, 64'h0000_0000_0000_0001, '0, alu_pkg::step_op2);
        push_op(alu_pkg::op_bsf, 64'h0000_0001_0000_0a00, '0, alu_pkg::step_op2);
        // Saturation at and beyond the signed limits
        push_op(alu_pkg::op_packsswb, 64'h8000_007f_0080_ff80, 64'h7fff_ff7f_0000_ffff,
                alu_pkg::step_op2);
        push_op(alu_pkg::op_packssdw, 64'h8000_0000_0000_7fff, 64'h0000_8000_ffff_7fff,
                alu_pkg::step_op2);
        push_op(alu_pkg::op_packssdw, 64'hffff_8000_7fff_ffff, 64'h8000_0001_0001_0000,
                alu_pkg::step_op2);
    endtask

    // Requester side, four phases on in_req and in_ack
    task automatic send_req(input xfer_pkg::alu_req_t r);
        in_data = r;
        in_req  = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!in_ack);
        check_req(i_dut.op_data, r);
        in_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (in_ack);
    endtask

    ////////////////////////////////////////////////////////////
    // Consumer with random and sometimes long stalls
    ////////////////////////////////////////////////////////////

    initial begin : consumer
        int unsigned hold;
        out_ack = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (out_req) begin
                if ($urandom_range(9, 0) == 0) hold = 30 + $urandom_range(40, 0);
                else hold = $urandom_range(3, 0);
                repeat (hold) begin
                    @(posedge clk);
                    #1;
                end
                if (exp_q.size() == 0) begin
                    other_errs++;
                    $display("A result arrived with no request outstanding");
                end else begin
                    check_res(out_data, exp_q.pop_front(), src_q.pop_front());
                end
                n_done++;
                out_ack = 1'b1;
                do begin
                    @(posedge clk);
                    #1;
                end while (out_req);
                repeat ($urandom_range(2, 0)) begin
                    @(posedge clk);
                    #1;
                end
                out_ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (n_ops > 0);
        repeat (n_ops * 64) @(posedge clk);
        $display("Timeout: %0d of %0d results seen", n_done, n_ops);
        $display("Finished with errors");
        $finish;
    end

    initial begin : main
        int unsigned seed_val;
        int unsigned gap;
        int          asrt_fails;
        seed_val = $urandom(66634);
        rst      = 1'b1;
        in_req   = 1'b0;
        in_data  = '0;
        build_directed();
        repeat (n_random) stim_q.push_back(rand_req());
        n_ops = stim_q.size();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (stim_q[i]) begin
            exp_q.push_back(predict_res(stim_q[i]));
            src_q.push_back(stim_q[i]);
            send_req(stim_q[i]);
            gap = $urandom_range(2, 0);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
        while (n_done < n_ops) @(posedge clk);
        // Idle time so a duplicated result would show up
        repeat (40) @(posedge clk);
        asrt_fails = i_dut.i_op_slot.i_hs_assert.fail_cnt
                   + i_dut.i_res_slot.i_hs_assert.fail_cnt;
        $display("Errors: value %0d, flags %0d, capture %0d, other %0d, assertions %0d",
                 value_errs, flag_errs, cap_errs, other_errs, asrt_fails);
        if (value_errs + flag_errs + cap_errs + other_errs + asrt_fails == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- exec_unit.sv
`default_nettype none

module exec_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_req,
    output logic               in_ack,
    input  xfer_pkg::alu_req_t in_data,
    output logic               out_req,
    input  logic               out_ack,
    output xfer_pkg::alu_res_t out_data
);

    logic               op_req;
    logic               op_ack;
    xfer_pkg::alu_req_t op_data;
    xfer_pkg::alu_res_t core_res;

    // Operand slot holds the pending operation
    hs_slot #(.payload_t(xfer_pkg::alu_req_t)) i_op_slot (
        .clk     (clk),
        .rst     (rst),
        .up_req  (in_req),
        .up_ack  (in_ack),
        .up_data (in_data),
        .dn_req  (op_req),
        .dn_ack  (op_ack),
        .dn_data (op_data)
    );

    alu_core i_core (
        .req (op_data),
        .res (core_res)
    );

    // Result slot captures the core output directly
    hs_slot #(.payload_t(xfer_pkg::alu_res_t)) i_res_slot (
        .clk     (clk),
        .rst     (rst),
        .up_req  (op_req),
        .up_ack  (op_ack),
        .up_data (core_res),
        .dn_req  (out_req),
        .dn_ack  (out_ack),
        .dn_data (out_data)
    );

endmodule

`default_nettype wire

//--- hs_slot.sv
`default_nettype none

module hs_slot #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     up_req,
    output logic     up_ack,
    input  payload_t up_data,
    output logic     dn_req,
    input  logic     dn_ack,
    output payload_t dn_data
);

    logic     full;
    payload_t data_q;

    ////////////////////////////////////////////////////////////
    // Upstream side, capture and four-phase ack
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            up_ack <= 1'b0;
        end else if (!up_req) begin
            up_ack <= 1'b0;
        end else if (!full && !up_ack) begin
            up_ack <= 1'b1;
        end
    end

    // Payload register, loaded only on capture
    always_ff @(posedge clk) begin
        if (up_req && !full && !up_ack) begin
            data_q <= up_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Downstream side, req held until ack returns
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            full   <= 1'b0;
            dn_req <= 1'b0;
        end else if (dn_req && dn_ack) begin
            full   <= 1'b0;
            dn_req <= 1'b0;
        end else begin
            if (up_req && !full && !up_ack) begin
                full <= 1'b1;
            end
            // Wait for the previous ack to fall first
            if (full && !dn_ack) begin
                dn_req <= 1'b1;
            end
        end
    end

    assign dn_data = data_q;

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
rm -f sim.log \
    && verilator --binary --timing --assert --top-module exec_tb -f all.f -o exec_sim \
    && ./obj_dir/exec_sim +verilator+error+limit+100 > sim.log 2>&1 \
    || echo "Build or simulation ended abnormally"
cat sim.log 2>/dev/null
grep -q "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- xfer_pkg.sv
`default_nettype none

package xfer_pkg;

    // Operation request, operand slot payload
    typedef struct packed {
        logic [alu_pkg::data_w-1:0] op1;
        logic [alu_pkg::data_w-1:0] op2;
        alu_pkg::alu_op_e           op;
        alu_pkg::add_step_e         step;
    } alu_req_t;

    // Result, result slot payload
    typedef struct packed {
        logic [alu_pkg::data_w-1:0] value;
        // Carry from adder or shifter
        logic                       cf;
        // Zero result or invalid scan
        logic                       zf;
    } alu_res_t;

endpackage

`default_nettype wire
